// ==== common/ctrl_defs.svh ====
`ifndef CTRL_DEFS_SVH
`define CTRL_DEFS_SVH

// instruction field widths
`define OPCODE_W    6
`define FUNCT_W     6
`define REG_W       5
`define SHAMT_W     5
`define IMM_W       16
`define TARGET_W    26
`define WORD_W      32
`define ALUOP_W     5

// primary opcodes, bits 31:26
`define OP_RTYPE    6'b000000
`define OP_REGIMM   6'b000001   // bltz/bgez, picked by rt
`define OP_ADDI     6'b001000
`define OP_ADDIU    6'b001001
`define OP_ANDI     6'b001100
`define OP_ORI      6'b001101
`define OP_XORI     6'b001110
`define OP_SLTI     6'b001010
`define OP_SLTIU    6'b001011
`define OP_LUI      6'b001111
`define OP_LW       6'b100011
`define OP_LH       6'b100001
`define OP_LB       6'b100000
`define OP_SW       6'b101011
`define OP_SH       6'b101001
`define OP_SB       6'b101000
`define OP_BEQ      6'b000100
`define OP_BNE      6'b000101
`define OP_BGTZ     6'b000111
`define OP_BLEZ     6'b000110
`define OP_J        6'b000010
`define OP_JAL      6'b000011

// function field, register format only
`define FN_ADD      6'b100000
`define FN_ADDU     6'b100001
`define FN_SUB      6'b100010
`define FN_AND      6'b100100
`define FN_OR       6'b100101
`define FN_NOR      6'b100111
`define FN_XOR      6'b100110
`define FN_SLL      6'b000000   // all-zero word here is the nop
`define FN_SRL      6'b000010   // rotr when rs[0] set
`define FN_SLLV     6'b000100
`define FN_SRLV     6'b000110   // rotrv when shamt[0] set
`define FN_SLT      6'b101010
`define FN_SLTU     6'b101011
`define FN_SRA      6'b000011
`define FN_SRAV     6'b000111
`define FN_MOVN     6'b001011
`define FN_MOVZ     6'b001010
`define FN_JR       6'b001000

// regimm selectors in rt
`define RT_BLTZ     5'b00000
`define RT_BGEZ     5'b00001

// ALU operation codes, as the execute stage expects them
`define ALU_NOP     5'b00000
`define ALU_ADD     5'b00001
`define ALU_ADDU    5'b00010
`define ALU_SUB     5'b00011
`define ALU_LUI     5'b01001
`define ALU_SRA     5'b01111
`define ALU_AND     5'b10000
`define ALU_OR      5'b10001
`define ALU_NOR     5'b10010
`define ALU_XOR     5'b10011
`define ALU_SLL     5'b10100
`define ALU_SRL     5'b10101
`define ALU_SLT     5'b10110
`define ALU_MOV     5'b10111   // shared by movn and movz
`define ALU_ROTRV   5'b11000
`define ALU_SRAV    5'b11001
`define ALU_SLTU    5'b11011
`define ALU_SLLV    5'b11101
`define ALU_SRLV    5'b11110
`define ALU_ROTR    5'b11111

// memory access size
`define ADDR_WORD   2'b00
`define ADDR_HALF   2'b01
`define ADDR_BYTE   2'b10

// jump kind
`define JUMP_NONE   2'b00
`define JUMP_DIRECT 2'b01
`define JUMP_REG    2'b10
`define JUMP_LINK   2'b11

// flow control
`define IN_CREDITS  4   // request buffer entries
`define OUT_CREDITS 2   // downstream slots after reset

`endif

// ==== common/ctrlPkg.sv ====
`include "ctrl_defs.svh"

package ctrlPkg;

    typedef struct packed {
        logic [`OPCODE_W-1:0] opcode;
        logic [`REG_W-1:0]    rs;
        logic [`REG_W-1:0]    rt;
        logic [`REG_W-1:0]    rd;
        logic [`SHAMT_W-1:0]  shamt;
        logic [`FUNCT_W-1:0]  funct;
    } rView_t;

    typedef struct packed {
        logic [`OPCODE_W-1:0] opcode;
        logic [`REG_W-1:0]    rs;
        logic [`REG_W-1:0]    rt;   // also the regimm selector
        logic [`IMM_W-1:0]    imm;
    } iView_t;

    typedef struct packed {
        logic [`OPCODE_W-1:0] opcode;
        logic [`TARGET_W-1:0] target;
    } jView_t;

    // one instruction word, three overlapping field layouts
    typedef union packed {
        rView_t rView;
        iView_t iView;
        jView_t jView;
    } instrWord_t;

    typedef struct packed {
        logic equalVal;
        logic gtZero;
        logic ltZero;
        logic beqz;     // rt == 0, drives movn/movz
    } condFlags_t;

    typedef struct packed {
        instrWord_t exInstr;
        instrWord_t memInstr;
        condFlags_t flags;      // belongs to exInstr
    } ctrlReq_t;

    typedef struct packed {
        logic                aluSrc;
        logic [`ALUOP_W-1:0] aluOp;
        logic                regDst;
        logic                regWrite;
    } exCtrl_t;

    typedef struct packed {
        logic [1:0] addrType;
        logic       memWrite;
        logic       memRead;
        logic       memToReg;
    } memCtrl_t;

    typedef struct packed {
        logic [1:0] jump;
        logic       pcSrc;
        logic       branch;
    } pcCtrl_t;

    typedef struct packed {
        exCtrl_t  ex;
        memCtrl_t mem;
        pcCtrl_t  pc;
    } ctrlResp_t;

endpackage

// ==== verilog/ctrlIntake.sv ====
`timescale 1ns/1ps
`include "ctrl_defs.svh"

module ctrlIntake import ctrlPkg::*; (
    input  logic     clk,
    input  logic     rstN,
    input  logic     reqValid,
    input  ctrlReq_t req,
    input  logic     pop,
    output logic     headValid,
    output ctrlReq_t head,
    output logic     reqCredit
);

    localparam int DEPTH = `IN_CREDITS;
    localparam int PTR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;
    localparam int CNT_W = $clog2(DEPTH + 1);

    ctrlReq_t         store [DEPTH];    // request slots
    logic [PTR_W-1:0] wrPtr;
    logic [PTR_W-1:0] rdPtr;
    logic [CNT_W-1:0] fill;             // occupied entries

    always_ff @(posedge clk or negedge rstN) begin
        if (!rstN) begin
            wrPtr     <= '0;
            rdPtr     <= '0;
            fill      <= '0;
            reqCredit <= 1'b0;
        end else begin
            if (reqValid) begin
                wrPtr <= (wrPtr == PTR_W'(DEPTH - 1)) ? '0 : wrPtr + 1'b1;  // wrap
            end
            if (pop) begin
                rdPtr <= (rdPtr == PTR_W'(DEPTH - 1)) ? '0 : rdPtr + 1'b1;
            end
            fill      <= fill + CNT_W'(reqValid) - CNT_W'(pop);
            reqCredit <= pop;   // slot freed, hand it back a cycle later
        end
    end

    always_ff @(posedge clk) begin
        if (reqValid) begin
            store[wrPtr] <= req;
        end
    end

    assign headValid = (fill != '0);
    assign head      = store[rdPtr];    // oldest entry

    // producer must hold back once every credit is spent
    intakeNoOverflow: assert property (@(posedge clk) disable iff (!rstN)
        (fill == CNT_W'(DEPTH)) |-> !reqValid)
        else $error("request sent while buffer full");

endmodule

// ==== decode/aluCtrlDecode.sv ====
`timescale 1ns/1ps
`include "ctrl_defs.svh"

module aluCtrlDecode import ctrlPkg::*; (
    input  instrWord_t instr,
    input  logic       beqz,
    output exCtrl_t    exCtrl
);

    // register format, result to rd
    function automatic exCtrl_t regOp(input logic [`ALUOP_W-1:0] op);
        return '{aluSrc: 1'b0, aluOp: op, regDst: 1'b1, regWrite: 1'b1};
    endfunction

    // immediate operand, result to rt
    function automatic exCtrl_t immOp(input logic [`ALUOP_W-1:0] op);
        return '{aluSrc: 1'b1, aluOp: op, regDst: 1'b0, regWrite: 1'b1};
    endfunction

    always_comb begin
        exCtrl = '0;    // unknown and unsupported codes
        case (instr.rView.opcode)
            `OP_RTYPE: begin
                case (instr.rView.funct)
                    `FN_ADD:  exCtrl = regOp(`ALU_ADD);
                    `FN_ADDU: exCtrl = regOp(`ALU_ADDU);
                    `FN_SUB:  exCtrl = regOp(`ALU_SUB);
                    `FN_AND:  exCtrl = regOp(`ALU_AND);
                    `FN_OR:   exCtrl = regOp(`ALU_OR);
                    `FN_NOR:  exCtrl = regOp(`ALU_NOR);
                    `FN_XOR:  exCtrl = regOp(`ALU_XOR);
                    `FN_SLLV: exCtrl = regOp(`ALU_SLLV);
                    `FN_SLT:  exCtrl = regOp(`ALU_SLT);
                    `FN_SLTU: exCtrl = regOp(`ALU_SLTU);
                    `FN_SRA:  exCtrl = regOp(`ALU_SRA);
                    `FN_SRAV: exCtrl = regOp(`ALU_SRAV);
                    `FN_SLL: begin
                        if (instr == {`WORD_W{1'b0}}) begin
                            exCtrl = '{1'b0, `ALU_NOP, 1'b0, 1'b0};  // nop
                        end else begin
                            exCtrl = regOp(`ALU_SLL);
                        end
                    end
                    `FN_SRL: begin
                        exCtrl = regOp(instr.rView.rs[0] ? `ALU_ROTR : `ALU_SRL);  // R bit
                    end
                    `FN_SRLV: begin
                        exCtrl = regOp(instr.rView.shamt[0] ? `ALU_ROTRV : `ALU_SRLV);
                    end
                    `FN_MOVN: exCtrl = '{1'b0, `ALU_MOV, 1'b1, ~beqz};  // write if rt != 0
                    `FN_MOVZ: exCtrl = '{1'b0, `ALU_MOV, 1'b1, beqz};   // write if rt == 0
                    `FN_JR:   exCtrl = '{1'b0, `ALU_ADD, 1'b0, 1'b0};   // no write back
                    default:  exCtrl = '0;
                endcase
            end
            `OP_ADDI:  exCtrl = immOp(`ALU_ADD);
            `OP_ADDIU: exCtrl = immOp(`ALU_ADDU);
            `OP_ANDI:  exCtrl = immOp(`ALU_AND);
            `OP_ORI:   exCtrl = immOp(`ALU_OR);
            `OP_XORI:  exCtrl = immOp(`ALU_XOR);
            `OP_SLTI:  exCtrl = immOp(`ALU_SLT);
            `OP_SLTIU: exCtrl = immOp(`ALU_SLTU);
            `OP_LUI:   exCtrl = immOp(`ALU_LUI);
            `OP_LW, `OP_LH, `OP_LB: begin
                exCtrl = immOp(`ALU_ADD);   // base + offset, loaded value to rt
            end
            `OP_SW, `OP_SH, `OP_SB: begin
                exCtrl = '{1'b1, `ALU_ADD, 1'b0, 1'b0};  // address only
            end
            `OP_JAL:   exCtrl = '{1'b0, `ALU_NOP, 1'b0, 1'b1};  // link register write
            default:   exCtrl = '0;  // branches, j and the rest
        endcase
    end

endmodule

// ==== decode/memCtrlDecode.sv ====
`timescale 1ns/1ps
`include "ctrl_defs.svh"

module memCtrlDecode import ctrlPkg::*; (
    input  instrWord_t instr,
    output memCtrl_t   memCtrl
);

    always_comb begin
        memCtrl = '0;   // no memory access
        case (instr.iView.opcode)
            `OP_LW:  memCtrl = '{`ADDR_WORD, 1'b0, 1'b1, 1'b1};
            `OP_LH:  memCtrl = '{`ADDR_HALF, 1'b0, 1'b1, 1'b1};
            `OP_LB:  memCtrl = '{`ADDR_BYTE, 1'b0, 1'b1, 1'b1};
            `OP_SW:  memCtrl = '{`ADDR_WORD, 1'b1, 1'b0, 1'b0};
            `OP_SH:  memCtrl = '{`ADDR_HALF, 1'b1, 1'b0, 1'b0};
            `OP_SB:  memCtrl = '{`ADDR_BYTE, 1'b1, 1'b0, 1'b0};
            default: memCtrl = '0;
        endcase
    end

endmodule

// ==== decode/branchResolve.sv ====
`timescale 1ns/1ps
`include "ctrl_defs.svh"

module branchResolve import ctrlPkg::*; (
    input  instrWord_t instr,
    input  condFlags_t flags,
    output pcCtrl_t    pcCtrl
);

    always_comb begin
        pcCtrl = '{jump: `JUMP_NONE, pcSrc: 1'b0, branch: 1'b0};  // sequential pc
        case (instr.jView.opcode)
            `OP_BEQ:  pcCtrl = '{`JUMP_NONE, flags.equalVal, 1'b1};
            `OP_BNE:  pcCtrl = '{`JUMP_NONE, ~flags.equalVal, 1'b1};
            `OP_BGTZ: pcCtrl = '{`JUMP_NONE, flags.gtZero, 1'b1};
            `OP_BLEZ: pcCtrl = '{`JUMP_NONE, ~flags.gtZero, 1'b1};
            `OP_REGIMM: begin
                if (instr.iView.rt == `RT_BLTZ) begin
                    pcCtrl = '{`JUMP_NONE, flags.ltZero, 1'b1};
                end else if (instr.iView.rt == `RT_BGEZ) begin
                    pcCtrl = '{`JUMP_NONE, ~flags.ltZero, 1'b1};
                end
            end
            `OP_RTYPE: begin
                if (instr.rView.funct == `FN_JR) begin
                    pcCtrl = '{`JUMP_REG, 1'b0, 1'b1};  // target from rs
                end
            end
            `OP_J:    pcCtrl = '{`JUMP_DIRECT, 1'b0, 1'b0};
            `OP_JAL:  pcCtrl = '{`JUMP_LINK, 1'b0, 1'b0};   // direct plus link
            default:  pcCtrl = '{`JUMP_NONE, 1'b0, 1'b0};
        endcase
    end

endmodule

// ==== verilog/ctrlIssue.sv ====
`timescale 1ns/1ps
`include "ctrl_defs.svh"

module ctrlIssue import ctrlPkg::*; (
    input  logic      clk,
    input  logic      rstN,
    input  logic      headValid,
    input  exCtrl_t   exCtrl,
    input  memCtrl_t  memCtrl,
    input  pcCtrl_t   pcCtrl,
    input  logic      respCredit,
    output logic      pop,
    output logic      respValid,
    output ctrlResp_t resp
);

    localparam int CNT_W = $clog2(`OUT_CREDITS + 1);

    logic [CNT_W-1:0] credits;  // free downstream slots

    assign pop = headValid && (credits != '0);  // issue edge doubles as buffer pop

    always_ff @(posedge clk or negedge rstN) begin
        if (!rstN) begin
            credits   <= CNT_W'(`OUT_CREDITS);
            respValid <= 1'b0;
        end else begin
            credits   <= credits - CNT_W'(pop) + CNT_W'(respCredit);
            respValid <= pop;
        end
    end

    always_ff @(posedge clk) begin
        if (pop) begin
            resp <= '{ex: exCtrl, mem: memCtrl, pc: pcCtrl};
        end
    end

    // consumer only returns credits it was given
    issueCreditMax: assert property (@(posedge clk) disable iff (!rstN)
        respCredit |-> (credits < CNT_W'(`OUT_CREDITS)))
        else $error("credit returned beyond OUT_CREDITS");

endmodule

// ==== verilog/controlUnit.sv ====
`timescale 1ns/1ps
`include "ctrl_defs.svh"

module controlUnit import ctrlPkg::*; (
    input  logic      clk,
    input  logic      rstN,
    input  logic      reqValid,
    input  ctrlReq_t  req,
    output logic      reqCredit,
    output logic      respValid,
    output ctrlResp_t resp,
    input  logic      respCredit
);

    localparam int UP_W = $clog2(`IN_CREDITS + 1);  // 0 to IN_CREDITS

    logic     headValid;
    ctrlReq_t head;
    logic     pop;
    exCtrl_t  exCtrl;
    memCtrl_t memCtrl;
    pcCtrl_t  pcCtrl;
    logic [UP_W-1:0] upCredits;     // producer's balance mirrored here

    ctrlIntake intake_i (
        .clk       (clk),
        .rstN      (rstN),
        .reqValid  (reqValid),
        .req       (req),
        .pop       (pop),
        .headValid (headValid),
        .head      (head),
        .reqCredit (reqCredit)
    );

    aluCtrlDecode aluDec_i (
        .instr  (head.exInstr),
        .beqz   (head.flags.beqz),
        .exCtrl (exCtrl)
    );

    memCtrlDecode memDec_i (
        .instr   (head.memInstr),   // memory stage word, independent of execute
        .memCtrl (memCtrl)
    );

    branchResolve branch_i (
        .instr  (head.exInstr),
        .flags  (head.flags),
        .pcCtrl (pcCtrl)
    );

    ctrlIssue issue_i (
        .clk        (clk),
        .rstN       (rstN),
        .headValid  (headValid),
        .exCtrl     (exCtrl),
        .memCtrl    (memCtrl),
        .pcCtrl     (pcCtrl),
        .respCredit (respCredit),
        .pop        (pop),
        .respValid  (respValid),
        .resp       (resp)
    );

    always_ff @(posedge clk or negedge rstN) begin
        if (!rstN) begin
            upCredits <= UP_W'(`IN_CREDITS);
        end else begin
            upCredits <= upCredits - UP_W'(reqValid) + UP_W'(reqCredit);
        end
    end

    upNoSendEmpty: assert property (@(posedge clk) disable iff (!rstN)
        reqValid |-> (upCredits != '0))
        else $error("request sent without an upstream credit");

endmodule

// ==== bench/ctrlRef.svh ====
`ifndef CTRL_REF_SVH
`define CTRL_REF_SVH

// expected response for one request, built field by field from the decode rules
function automatic ctrlResp_t refDecode(input ctrlReq_t req);
    ctrlResp_t           want;
    logic [`OPCODE_W-1:0] op;
    logic [`OPCODE_W-1:0] memOp;
    logic [`FUNCT_W-1:0]  fn;
    logic [`ALUOP_W-1:0]  alu;
    logic                 known;
    logic                 isStore;
    logic                 isLoad;
    op      = req.exInstr.rView.opcode;
    fn      = req.exInstr.rView.funct;
    memOp   = req.memInstr.iView.opcode;
    want    = '0;
    alu     = `ALU_NOP;
    known   = 1'b1;
    isStore = (op == `OP_SW) || (op == `OP_SH) || (op == `OP_SB);
    if (op == `OP_RTYPE) begin
        case (fn)
            `FN_ADD, `FN_JR:    alu = `ALU_ADD;
            `FN_ADDU:           alu = `ALU_ADDU;
            `FN_SUB:            alu = `ALU_SUB;
            `FN_AND:            alu = `ALU_AND;
            `FN_OR:             alu = `ALU_OR;
            `FN_NOR:            alu = `ALU_NOR;
            `FN_XOR:            alu = `ALU_XOR;
            `FN_SLL:            alu = `ALU_SLL;
            `FN_SLLV:           alu = `ALU_SLLV;
            `FN_SLT:            alu = `ALU_SLT;
            `FN_SLTU:           alu = `ALU_SLTU;
            `FN_SRA:            alu = `ALU_SRA;
            `FN_SRAV:           alu = `ALU_SRAV;
            `FN_MOVN, `FN_MOVZ: alu = `ALU_MOV;
            `FN_SRL:  alu = req.exInstr.rView.rs[0] ? `ALU_ROTR : `ALU_SRL;  // R bit in rs
            `FN_SRLV: alu = req.exInstr.rView.shamt[0] ? `ALU_ROTRV : `ALU_SRLV;
            default:            known = 1'b0;   // hi/lo group and the like
        endcase
        if (known && (req.exInstr != '0)) begin    // zero word stays a nop
            want.ex.aluOp    = alu;
            want.ex.regDst   = (fn != `FN_JR);
            want.ex.regWrite = (fn != `FN_JR);
            if (fn == `FN_MOVN) want.ex.regWrite = !req.flags.beqz;
            if (fn == `FN_MOVZ) want.ex.regWrite = req.flags.beqz;
        end
    end else begin
        case (op)
            `OP_ADDI, `OP_LW, `OP_LH, `OP_LB, `OP_SW, `OP_SH, `OP_SB: alu = `ALU_ADD;
            `OP_ADDIU: alu = `ALU_ADDU;
            `OP_ANDI:  alu = `ALU_AND;
            `OP_ORI:   alu = `ALU_OR;
            `OP_XORI:  alu = `ALU_XOR;
            `OP_SLTI:  alu = `ALU_SLT;
            `OP_SLTIU: alu = `ALU_SLTU;
            `OP_LUI:   alu = `ALU_LUI;
            default:   known = 1'b0;
        endcase
        if (known) begin
            want.ex.aluSrc   = 1'b1;
            want.ex.aluOp    = alu;
            want.ex.regWrite = !isStore;    // stores only form an address
        end
        if (op == `OP_JAL) want.ex.regWrite = 1'b1;     // link write, nothing else
    end
    // memory bundle from the memory-stage word only
    isLoad  = (memOp == `OP_LW) || (memOp == `OP_LH) || (memOp == `OP_LB);
    isStore = (memOp == `OP_SW) || (memOp == `OP_SH) || (memOp == `OP_SB);
    if (isLoad || isStore) begin
        if ((memOp == `OP_LH) || (memOp == `OP_SH)) want.mem.addrType = `ADDR_HALF;
        else if ((memOp == `OP_LB) || (memOp == `OP_SB)) want.mem.addrType = `ADDR_BYTE;
        else want.mem.addrType = `ADDR_WORD;
        want.mem.memWrite = isStore;
        want.mem.memRead  = isLoad;
        want.mem.memToReg = isLoad;
    end
    // pc bundle
    case (op)
        `OP_BEQ:  want.pc = '{`JUMP_NONE, req.flags.equalVal, 1'b1};
        `OP_BNE:  want.pc = '{`JUMP_NONE, !req.flags.equalVal, 1'b1};
        `OP_BGTZ: want.pc = '{`JUMP_NONE, req.flags.gtZero, 1'b1};
        `OP_BLEZ: want.pc = '{`JUMP_NONE, !req.flags.gtZero, 1'b1};
        `OP_REGIMM: begin
            if (req.exInstr.iView.rt == `RT_BLTZ) want.pc = '{`JUMP_NONE, req.flags.ltZero, 1'b1};
            if (req.exInstr.iView.rt == `RT_BGEZ) want.pc = '{`JUMP_NONE, !req.flags.ltZero, 1'b1};
        end
        `OP_RTYPE: if (fn == `FN_JR) want.pc = '{`JUMP_REG, 1'b0, 1'b1};
        `OP_J:    want.pc.jump = `JUMP_DIRECT;
        `OP_JAL:  want.pc.jump = `JUMP_LINK;
        default:  want.pc = '0;
    endcase
    return want;
endfunction

`endif

// ==== bench/controlUnitTb.sv ====
`timescale 1ns/1ps
`include "ctrl_defs.svh"

module controlUnitTb import ctrlPkg::*; ();

    `include "ctrlRef.svh"

    localparam int NUM_REQ = 400;
    localparam int LIMIT   = NUM_REQ * 8 + 200;    // cycle budget for the whole run

    logic      clk;
    logic      rstN;
    logic      reqValid;
    ctrlReq_t  req;
    logic      reqCredit;
    logic      respValid;
    ctrlResp_t resp;
    logic      respCredit;

    ctrlResp_t expQ [$];    // expected responses, oldest first
    int        dueQ [$];    // cycles at which a downstream credit goes back
    int        cycles   = 0;
    int        sent     = 0;
    int        returned = 0;    // reqCredit pulses seen
    int        due;
    ctrlReq_t  nextReq;
    ctrlResp_t want;

    // kept functions, then mult and mfhi which must decode to zeros
    logic [`FUNCT_W-1:0] rFuncts [20] = '{
        `FN_ADD, `FN_ADDU, `FN_SUB, `FN_AND, `FN_OR, `FN_NOR, `FN_XOR, `FN_SLL,
        `FN_SRL, `FN_SLLV, `FN_SRLV, `FN_SLT, `FN_SLTU, `FN_SRA, `FN_SRAV,
        `FN_MOVN, `FN_MOVZ, `FN_JR, 6'b011000, 6'b010000};

    // non-register opcodes, last three unknown here (special2, special3, spare)
    logic [`OPCODE_W-1:0] opcodes [24] = '{
        `OP_ADDI, `OP_ADDIU, `OP_ANDI, `OP_ORI, `OP_XORI, `OP_SLTI, `OP_SLTIU,
        `OP_LUI, `OP_LW, `OP_LH, `OP_LB, `OP_SW, `OP_SH, `OP_SB, `OP_BEQ,
        `OP_BNE, `OP_BGTZ, `OP_BLEZ, `OP_REGIMM, `OP_J, `OP_JAL,
        6'b011100, 6'b011111, 6'b111111};

    controlUnit controlUnit_i (
        .clk        (clk),
        .rstN       (rstN),
        .reqValid   (reqValid),
        .req        (req),
        .reqCredit  (reqCredit),
        .respValid  (respValid),
        .resp       (resp),
        .respCredit (respCredit)
    );

    always #50 clk = ~clk;  // 100 ns period

    task automatic abortRun(input string why);
        $display("%s", why);
        $display("TEST FAIL");
        $fatal(1, "simulation stopped");
    endtask

    task automatic reportMismatch(input string name, input logic [16:0] got,
                                  input logic [16:0] expected);
        $display("[ERROR] %s got 0x%0h expected 0x%0h", name, got, expected);
        abortRun("response does not match the reference decode");
    endtask

    // random execute word: nop, register format or another opcode
    function automatic instrWord_t makeExInstr();
        instrWord_t w;
        int         kind;
        w    = $urandom();
        kind = $urandom_range(0, 9);
        if (kind == 0) begin
            w = '0;
        end else if (kind < 5) begin
            w.rView.opcode = `OP_RTYPE;
            w.rView.funct  = rFuncts[$urandom_range(0, 19)];    // rs/shamt bits stay random
        end else begin
            w.iView.opcode = opcodes[$urandom_range(0, 23)];
            if (w.iView.opcode == `OP_REGIMM) begin
                w.iView.rt = 5'($urandom_range(0, 2));  // 2 is an unused selector
            end
        end
        return w;
    endfunction

    function automatic instrWord_t makeMemInstr();
        instrWord_t w;
        w              = $urandom();
        w.iView.opcode = opcodes[$urandom_range(0, 23)];
        return w;
    endfunction

    always @(posedge clk) cycles <= cycles + 1;

    // producer, one request per cycle at most, only while holding a credit
    always @(posedge clk) begin
        if (!rstN) begin
            reqValid <= 1'b0;
        end else begin
            if (reqCredit) returned++;
            assert (returned <= sent)
                else abortRun("reqCredit pulsed more often than requests were sent");
            if ((sent < NUM_REQ) && ((sent - returned) < `IN_CREDITS) &&
                ($urandom_range(0, 1) == 1)) begin
                nextReq.exInstr  = makeExInstr();
                nextReq.memInstr = makeMemInstr();
                nextReq.flags    = 4'($urandom_range(0, 15));
                expQ.push_back(refDecode(nextReq));
                req      <= nextReq;
                reqValid <= 1'b1;
                sent++;
            end else begin
                reqValid <= 1'b0;
            end
        end
    end

    // consumer, hands each credit back 0 to 12 cycles after its response
    always @(posedge clk) begin
        if (!rstN) begin
            respCredit <= 1'b0;
        end else begin
            if (respValid) begin
                due = cycles + $urandom_range(0, 12);
                if ((dueQ.size() != 0) && (due <= dueQ[$])) due = dueQ[$] + 1;  // one per cycle
                dueQ.push_back(due);
            end
            if ((dueQ.size() != 0) && (dueQ[0] <= cycles)) begin
                respCredit <= 1'b1;
                void'(dueQ.pop_front());
            end else begin
                respCredit <= 1'b0;
            end
        end
    end

    // scoreboard
    always @(posedge clk) begin
        if (rstN && respValid) begin
            assert (expQ.size() != 0) else abortRun("response arrived with none expected");
            want = expQ.pop_front();
            assert (resp.ex == want.ex) else reportMismatch("resp.ex", resp.ex, want.ex);
            assert (resp.mem == want.mem) else reportMismatch("resp.mem", resp.mem, want.mem);
            assert (resp.pc == want.pc) else reportMismatch("resp.pc", resp.pc, want.pc);
        end
    end

    initial begin
        void'($urandom(95809));
        clk        = 1'b0;
        rstN       = 1'b0;
        reqValid   = 1'b0;
        req        = '0;
        respCredit = 1'b0;
        repeat (10) @(posedge clk);
        rstN <= 1'b1;
        while (!((sent == NUM_REQ) && (expQ.size() == 0)) && (cycles < LIMIT)) begin
            @(negedge clk);     // away from the sampling edge
        end
        if ((sent == NUM_REQ) && (expQ.size() == 0)) begin
            if (returned == sent) begin
                $display("TEST PASS");
                $finish;
            end else begin
                abortRun("upstream credits still missing after the last response");
            end
        end else begin
            abortRun("timeout, responses still missing at the cycle limit");
        end
    end

endmodule

// ==== verilog.f ====
+incdir+common
+incdir+bench
common/ctrlPkg.sv
verilog/ctrlIntake.sv
decode/aluCtrlDecode.sv
decode/memCtrlDecode.sv
decode/branchResolve.sv
verilog/ctrlIssue.sv
verilog/controlUnit.sv
bench/controlUnitTb.sv

// ==== Bender.yml ====
package:
  name: control_unit

sources:
  - include_dirs:
      - common
    files:
      - common/ctrlPkg.sv
      - verilog/ctrlIntake.sv
      - decode/aluCtrlDecode.sv
      - decode/memCtrlDecode.sv
      - decode/branchResolve.sv
      - verilog/ctrlIssue.sv
      - verilog/controlUnit.sv
  - target: test
    include_dirs:
      - common
      - bench
    files:
      - bench/controlUnitTb.sv
